/* hdl/mem_pkg.sv */
package mem_pkg;

    localparam int ROB_ID_W    = 4;
    localparam int QUEUE_DEPTH = 4;

    // Access size and signedness codes
    localparam logic [2:0] F3_BYTE   = 3'd0;
    localparam logic [2:0] F3_HALF   = 3'd1;
    localparam logic [2:0] F3_WORD   = 3'd2;
    localparam logic [2:0] F3_BYTE_U = 3'd4;
    localparam logic [2:0] F3_HALF_U = 3'd5;

    typedef logic [ROB_ID_W-1:0] rob_id_t; // Zero means no tag / no result
    typedef logic [31:0]         word_t;
    typedef logic [7:0]          byte_t;
    typedef logic [2:0]          func3_t;
    typedef logic [11:0]         offset_t; // Signed immediate

    // Memory unit sequencer states
    typedef enum logic [1:0] {
        IDLE,
        LOADING,
        STORING
    } lsu_state_t;

endpackage

/* hdl/mem_issue_if.sv */
`timescale 1ns/1ps

interface mem_issue_if
    import mem_pkg::*;
();

    logic    head_valid;  // Head present, operands ready
    logic    head_store;
    func3_t  head_op;
    word_t   head_base;
    word_t   head_data;
    offset_t head_offset;
    rob_id_t head_dest;
    logic    head_take;   // One-cycle pop strobe

    modport queue (
        output head_valid, head_store, head_op, head_base,
        output head_data, head_offset, head_dest,
        input  head_take
    );

    modport ctrl (
        input  head_valid, head_store, head_op,
        output head_take
    );

    // Store flag lets the datapath zero the result of a store
    modport data (
        input head_base, head_data, head_offset, head_dest, head_store
    );

endinterface

/* hdl/mem_op_queue.sv */
`timescale 1ns/1ps

module mem_op_queue
    import mem_pkg::*;
(
    input  logic       clk_in,
    input  logic       rst_n,
    input  logic       disp_en,
    input  logic       disp_store,
    input  func3_t     disp_op,
    input  word_t      disp_base,
    input  word_t      disp_data,
    input  rob_id_t    disp_base_tag,
    input  rob_id_t    disp_data_tag,
    input  rob_id_t    disp_dest,
    input  offset_t    disp_offset,
    input  rob_id_t    cdb_rob_id,
    input  word_t      cdb_value,
    output logic       queue_full,
    mem_issue_if.queue issue
);

    // Entry storage, occupancy tracked by count
    logic    ent_store    [QUEUE_DEPTH];
    func3_t  ent_op       [QUEUE_DEPTH];
    word_t   ent_base     [QUEUE_DEPTH];
    rob_id_t ent_base_tag [QUEUE_DEPTH];
    word_t   ent_data     [QUEUE_DEPTH];
    rob_id_t ent_data_tag [QUEUE_DEPTH];
    offset_t ent_offset   [QUEUE_DEPTH];
    rob_id_t ent_dest     [QUEUE_DEPTH];

    logic [$clog2(QUEUE_DEPTH)-1:0] head_ptr;
    logic [$clog2(QUEUE_DEPTH)-1:0] tail_ptr;
    logic [$clog2(QUEUE_DEPTH):0]   count;

    logic    push;
    word_t   in_base;
    rob_id_t in_base_tag;
    word_t   in_data;
    rob_id_t in_data_tag;

    function automatic logic cdb_hit(input rob_id_t tag, input rob_id_t bus_id);
        return (tag != '0) && (tag == bus_id);
    endfunction

    assign queue_full = (count == QUEUE_DEPTH);
    assign push       = disp_en && !queue_full;

    // Operand broadcast in the dispatch cycle is caught here
    always_comb begin
        in_base     = disp_base;
        in_base_tag = disp_base_tag;
        in_data     = disp_data;
        in_data_tag = disp_data_tag;
        if (cdb_hit(disp_base_tag, cdb_rob_id)) begin
            in_base     = cdb_value;
            in_base_tag = '0;
        end
        if (cdb_hit(disp_data_tag, cdb_rob_id)) begin
            in_data     = cdb_value;
            in_data_tag = '0;
        end
    end

    always_ff @(posedge clk_in) begin
        for (int i = 0; i < QUEUE_DEPTH; i++) begin
            if (cdb_hit(ent_base_tag[i], cdb_rob_id)) begin
                ent_base[i]     <= cdb_value;
                ent_base_tag[i] <= '0;
            end
            if (cdb_hit(ent_data_tag[i], cdb_rob_id)) begin
                ent_data[i]     <= cdb_value;
                ent_data_tag[i] <= '0;
            end
        end
        if (push) begin // Overrides wakeup on the tail slot
            ent_store[tail_ptr]    <= disp_store;
            ent_op[tail_ptr]       <= disp_op;
            ent_base[tail_ptr]     <= in_base;
            ent_base_tag[tail_ptr] <= in_base_tag;
            ent_data[tail_ptr]     <= in_data;
            ent_data_tag[tail_ptr] <= in_data_tag;
            ent_offset[tail_ptr]   <= disp_offset;
            ent_dest[tail_ptr]     <= disp_dest;
        end
    end

    always_ff @(posedge clk_in) begin
        if (!rst_n) begin
            head_ptr <= '0;
            tail_ptr <= '0;
            count    <= '0;
        end else begin
            if (push) tail_ptr <= tail_ptr + 1'b1;
            if (issue.head_take) head_ptr <= head_ptr + 1'b1;
            case ({push, issue.head_take})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    // Head fields straight from the oldest entry
    assign issue.head_valid  = (count != '0) && (ent_base_tag[head_ptr] == '0)
                               && (!ent_store[head_ptr] || ent_data_tag[head_ptr] == '0);
    assign issue.head_store  = ent_store[head_ptr];
    assign issue.head_op     = ent_op[head_ptr];
    assign issue.head_base   = ent_base[head_ptr];
    assign issue.head_data   = ent_data[head_ptr];
    assign issue.head_offset = ent_offset[head_ptr];
    assign issue.head_dest   = ent_dest[head_ptr];

endmodule

/* hdl/lsu_ctrl.sv */
`timescale 1ns/1ps

module lsu_ctrl
    import mem_pkg::*;
(
    input  logic      clk_in,
    input  logic      rst_n,
    mem_issue_if.ctrl issue,
    input  logic      mem_success,
    output logic      mem_en,
    output logic      mem_wr,
    output logic      step,
    output logic      done
);

    lsu_state_t state;
    logic [1:0] bytes_left; // Accesses still owed after the current one
    logic [1:0] first_count;
    logic       last_byte;

    // Byte count of the head op, minus one
    always_comb begin
        case (issue.head_op)
            F3_BYTE, F3_BYTE_U: first_count = 2'd0;
            F3_HALF, F3_HALF_U: first_count = 2'd1;
            default:            first_count = 2'd3; // Word
        endcase
    end

    assign last_byte = (bytes_left == 2'd0);

    assign issue.head_take = (state == IDLE) && issue.head_valid;

    assign mem_en = (state != IDLE);
    assign mem_wr = (state == STORING);
    assign step   = mem_en && mem_success && !last_byte;
    assign done   = mem_en && mem_success && last_byte;

    always_ff @(posedge clk_in) begin
        if (!rst_n) begin
            state      <= IDLE;
            bytes_left <= 2'd0;
        end else begin
            case (state)
                IDLE: begin
                    if (issue.head_take) begin
                        bytes_left <= first_count;
                        state      <= issue.head_store ? STORING : LOADING;
                    end
                end
                LOADING, STORING: begin
                    if (done) begin
                        state <= IDLE; // Result shows on the same edge
                    end else if (step) begin
                        bytes_left <= bytes_left - 2'd1;
                    end
                end
                default: state <= IDLE;
            endcase
        end
    end

endmodule

/* hdl/byte_datapath.sv */
`timescale 1ns/1ps

module byte_datapath
    import mem_pkg::*;
(
    input  logic      clk_in,
    input  logic      rst_n,
    mem_issue_if.data issue,
    input  logic      take,
    input  func3_t    load_op,
    input  logic      step,
    input  logic      done,
    input  byte_t     mem_din,
    output word_t     mem_addr,
    output byte_t     mem_dout,
    output rob_id_t   res_rob_id,
    output word_t     res_value
);

    word_t   addr_q;
    word_t   shift_q;  // Store bytes leave at the bottom, load bytes enter at the top
    rob_id_t dest_q;
    func3_t  op_q;
    logic    store_q;
    word_t   gathered;
    word_t   load_value;

    // Includes the byte arriving this cycle
    assign gathered = {mem_din, shift_q[31:8]};

    always_comb begin
        case (op_q)
            F3_BYTE:   load_value = {{24{gathered[31]}}, gathered[31:24]};
            F3_HALF:   load_value = {{16{gathered[31]}}, gathered[31:16]};
            F3_BYTE_U: load_value = {24'h0, gathered[31:24]};
            F3_HALF_U: load_value = {16'h0, gathered[31:16]};
            default:   load_value = gathered;
        endcase
    end

    always_ff @(posedge clk_in) begin
        if (take) begin
            addr_q  <= issue.head_base + {{20{issue.head_offset[11]}}, issue.head_offset};
            shift_q <= issue.head_data;
            dest_q  <= issue.head_dest;
            op_q    <= load_op;
            store_q <= issue.head_store;
        end else if (step) begin
            addr_q  <= addr_q + 32'd1;
            shift_q <= gathered;
        end
    end

    always_ff @(posedge clk_in) begin
        if (!rst_n) begin
            res_rob_id <= '0;
        end else begin
            res_rob_id <= done ? dest_q : '0; // Single-cycle result strobe
        end
    end

    always_ff @(posedge clk_in) begin
        if (done) begin
            res_value <= store_q ? '0 : load_value;
        end
    end

    assign mem_addr = addr_q;
    assign mem_dout = shift_q[7:0];

endmodule

/* hdl/mem_unit_top.sv */
`timescale 1ns/1ps

module mem_unit_top
    import mem_pkg::*;
(
    input  logic    clk_in,
    input  logic    rst_n,
    input  logic    disp_en,
    input  logic    disp_store,
    input  func3_t  disp_op,
    input  word_t   disp_base,
    input  rob_id_t disp_base_tag,
    input  word_t   disp_data,
    input  rob_id_t disp_data_tag,
    input  offset_t disp_offset,
    input  rob_id_t disp_dest,
    output logic    queue_full,
    input  rob_id_t cdb_rob_id,
    input  word_t   cdb_value,
    output logic    mem_en,
    output logic    mem_wr,
    output word_t   mem_addr,
    output byte_t   mem_dout,
    input  byte_t   mem_din,
    input  logic    mem_success,
    output rob_id_t res_rob_id,
    output word_t   res_value
);

    logic step;
    logic done;

    mem_issue_if issue_bus ();

    mem_op_queue u_queue (
        .clk_in        (clk_in),
        .rst_n         (rst_n),
        .disp_en       (disp_en),
        .disp_store    (disp_store),
        .disp_op       (disp_op),
        .disp_base     (disp_base),
        .disp_data     (disp_data),
        .disp_base_tag (disp_base_tag),
        .disp_data_tag (disp_data_tag),
        .disp_dest     (disp_dest),
        .disp_offset   (disp_offset),
        .cdb_rob_id    (cdb_rob_id),
        .cdb_value     (cdb_value),
        .queue_full    (queue_full),
        .issue         (issue_bus)
    );

    lsu_ctrl u_ctrl (
        .clk_in      (clk_in),
        .rst_n       (rst_n),
        .issue       (issue_bus),
        .mem_success (mem_success),
        .mem_en      (mem_en),
        .mem_wr      (mem_wr),
        .step        (step),
        .done        (done)
    );

    byte_datapath u_datapath (
        .clk_in     (clk_in),
        .rst_n      (rst_n),
        .issue      (issue_bus),
        .take       (issue_bus.head_take),
        .load_op    (issue_bus.head_op),  // Latched by the datapath at take
        .step       (step),
        .done       (done),
        .mem_din    (mem_din),
        .mem_addr   (mem_addr),
        .mem_dout   (mem_dout),
        .res_rob_id (res_rob_id),
        .res_value  (res_value)
    );

endmodule

/* bench/tb_mem_model.sv */
`timescale 1ns/1ps

module tb_mem_model
    import mem_pkg::*;
(
    input  logic  clk_in,
    input  logic  mem_en,
    input  logic  mem_wr,
    input  word_t mem_addr,
    input  byte_t mem_dout,
    output byte_t mem_din,
    output logic  mem_success
);

    byte_t  mem [256];
    integer seed;

    initial begin
        seed        = 32'h5a31;
        mem_success = 1'b0;
        for (int a = 0; a < 256; a++) begin
            mem[a] <= byte_t'(a * 37 + 11); // Odd multiplier keeps every byte distinct
        end
    end

    assign mem_din = mem[mem_addr[7:0]];

    // Store lands on a successful cycle, then a new stall decision
    always @(posedge clk_in) begin
        if (mem_en && mem_wr && mem_success) begin
            mem[mem_addr[7:0]] <= mem_dout;
        end
        #5;
        mem_success = ({$random(seed)} % 3) != 0; // About two in three
    end

endmodule

/* bench/tb_mem_unit.sv */
`timescale 1ns/1ps

module tb_mem_unit
    import mem_pkg::*;
();

    localparam int ROWS           = 14;
    localparam int TIMEOUT_CYCLES = ROWS * 40;

    typedef struct packed {
        logic    st;
        func3_t  op;
        word_t   base;
        rob_id_t tag;   // Base tag woken later by the bench
        offset_t off;
        word_t   data;
        rob_id_t dest;
        word_t   exp;
        logic    wake;  // Broadcast the blocked base after this row
    } row_t;

    logic    clk_in, rst_n, disp_en, disp_store, queue_full, mem_en, mem_wr, mem_success;
    func3_t  disp_op;
    word_t   disp_base, disp_data, cdb_value, mem_addr, res_value;
    rob_id_t disp_base_tag, disp_data_tag, disp_dest, cdb_rob_id, res_rob_id;
    offset_t disp_offset;
    byte_t   mem_dout, mem_din;

    row_t tbl [ROWS];
    int   exp_q [$];   // Row indices in dispatch order
    int   errors = 0;
    int   checks = 0;
    int   cycles = 0;
    int   blocked = 0;

    mem_unit_top UUT (.*);

    tb_mem_model u_mem (
        .clk_in(clk_in), .mem_en(mem_en), .mem_wr(mem_wr), .mem_addr(mem_addr),
        .mem_dout(mem_dout), .mem_din(mem_din), .mem_success(mem_success)
    );

    initial begin
        clk_in = 1'b0;
        forever #20 clk_in = ~clk_in;
    end

    task automatic report_mismatch(input string name, input word_t got, input word_t want);
        errors++;
        $display("FAIL %s: got 0x%08h, expected 0x%08h", name, got, want);
    endtask

    // Holds disp_en until an edge where the queue had room
    task automatic dispatch_row(input int i);
        logic was_full;
        disp_en       = 1'b1;
        disp_store    = tbl[i].st;
        disp_op       = tbl[i].op;
        disp_base     = (tbl[i].tag != '0) ? ~tbl[i].base : tbl[i].base;
        disp_base_tag = tbl[i].tag;
        disp_offset   = tbl[i].off;
        disp_data     = tbl[i].data;
        disp_dest     = tbl[i].dest;
        do begin
            was_full = queue_full;
            @(posedge clk_in);
            #5;
        end while (was_full);
        disp_en = 1'b0;
        exp_q.push_back(i);
    endtask

    task automatic wait_drained();
        while (exp_q.size() != 0) begin
            @(posedge clk_in);
            #5;
        end
    endtask

    // Results are compared in program order
    always @(negedge clk_in) begin : result_monitor
        int idx;
        if (rst_n && res_rob_id != '0) begin
            if (exp_q.size() == 0) begin
                errors++;
                $display("Result with tag %0d appeared while nothing was pending", res_rob_id);
            end else begin
                idx = exp_q.pop_front();
                checks += 2;
                if (res_rob_id !== tbl[idx].dest)
                    report_mismatch("res_rob_id", res_rob_id, tbl[idx].dest);
                if (res_value !== tbl[idx].exp)
                    report_mismatch("res_value", res_value, tbl[idx].exp);
            end
        end
    end

    // Cycle watchdog
    initial begin
        while (cycles < TIMEOUT_CYCLES) begin
            @(posedge clk_in);
            cycles++;
        end
        $display("Timeout after %0d cycles, %0d results never arrived", cycles, exp_q.size());
        $display("Checks: %0d, errors: %0d", checks, errors + 1);
        $display("ERRORS FOUND");
        $finish;
    end

    initial begin
        // st  op  base  tag  off  data  dest  expected  wake
        tbl[0]  = '{1'b1, F3_WORD,   32'h40, 4'd0, 12'h000, 32'h8765_F0A1, 4'd1,  32'h0, 1'b0};
        tbl[1]  = '{1'b0, F3_WORD,   32'h40, 4'd0, 12'h000, 32'h0, 4'd2,  32'h8765_F0A1, 1'b0};
        tbl[2]  = '{1'b0, F3_BYTE,   32'h40, 4'd0, 12'h000, 32'h0, 4'd3,  32'hFFFF_FFA1, 1'b0};
        tbl[3]  = '{1'b0, F3_BYTE_U, 32'h50, 4'd0, 12'hFF1, 32'h0, 4'd4,  32'h0000_00F0, 1'b0};
        tbl[4]  = '{1'b0, F3_HALF,   32'h42, 4'd0, 12'h000, 32'h0, 4'd5,  32'hFFFF_8765, 1'b0};
        tbl[5]  = '{1'b0, F3_HALF_U, 32'h40, 4'd0, 12'h002, 32'h0, 4'd6,  32'h0000_8765, 1'b0};
        tbl[6]  = '{1'b1, F3_HALF,   32'h60, 4'd0, 12'h002, 32'h1234_C3B2, 4'd7, 32'h0, 1'b0};
        tbl[7]  = '{1'b1, F3_BYTE,   32'h60, 4'd0, 12'h004, 32'h0000_007E, 4'd8, 32'h0, 1'b0};
        tbl[8]  = '{1'b0, F3_WORD,   32'h3E, 4'd9, 12'h002, 32'h0, 4'd10, 32'h8765_F0A1, 1'b0};
        tbl[9]  = '{1'b0, F3_HALF,   32'h62, 4'd0, 12'h000, 32'h0, 4'd11, 32'hFFFF_C3B2, 1'b0};
        tbl[10] = '{1'b0, F3_BYTE,   32'h64, 4'd0, 12'h000, 32'h0, 4'd12, 32'h0000_007E, 1'b0};
        tbl[11] = '{1'b1, F3_WORD,   32'h70, 4'd0, 12'hFF0, 32'hDEAD_BEEF, 4'd13, 32'h0, 1'b1};
        tbl[12] = '{1'b0, F3_BYTE_U, 32'h60, 4'd0, 12'h003, 32'h0, 4'd14, 32'h0000_00DE, 1'b0};
        tbl[13] = '{1'b0, F3_HALF,   32'h60, 4'd0, 12'h000, 32'h0, 4'd15, 32'hFFFF_BEEF, 1'b0};

        rst_n = 1'b0;
        disp_en = 1'b0;
        disp_store = 1'b0;
        disp_op = '0;
        disp_base = '0;
        disp_base_tag = '0;
        disp_data = '0;
        disp_data_tag = '0;
        disp_offset = '0;
        disp_dest = '0;
        cdb_rob_id = '0;
        cdb_value = '0;

        repeat (10) @(posedge clk_in);
        #5;
        checks += 3;
        if (res_rob_id !== '0) report_mismatch("res_rob_id", res_rob_id, 0);
        if (mem_en !== 1'b0) report_mismatch("mem_en", mem_en, 0);
        if (queue_full !== 1'b0) report_mismatch("queue_full", queue_full, 0);
        rst_n = 1'b1;

        for (int i = 0; i < ROWS; i++) begin
            if (tbl[i].tag != '0) begin
                wait_drained(); // Tagged op becomes the head
                blocked = i;
            end
            dispatch_row(i);
            if (tbl[i].wake) begin
                checks++;
                if (queue_full !== 1'b1) report_mismatch("queue_full", queue_full, 1);
                repeat (5) begin
                    checks += 2;
                    if (mem_en !== 1'b0) report_mismatch("mem_en", mem_en, 0);
                    if (res_rob_id !== '0) report_mismatch("res_rob_id", res_rob_id, 0);
                    @(posedge clk_in);
                    #5;
                end
                cdb_rob_id = tbl[blocked].tag;
                cdb_value  = tbl[blocked].base;
                @(posedge clk_in);
                #5;
                cdb_rob_id = '0;
                cdb_value  = '0;
            end
        end
        wait_drained();

        $display("Checks: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("NO ERRORS");
        end else begin
            $display("ERRORS FOUND");
        end
        $finish;
    end

endmodule

/* vlog.f */
hdl/mem_pkg.sv
hdl/mem_issue_if.sv
hdl/mem_op_queue.sv
hdl/lsu_ctrl.sv
hdl/byte_datapath.sv
hdl/mem_unit_top.sv
bench/tb_mem_model.sv
bench/tb_mem_unit.sv

/* Makefile */
TOOL     = verilator
FLAGS    = --binary --timing
TOP      = tb_mem_unit
FILELIST = vlog.f
BUILD    = obj_dir

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator and run the testbench"
	@echo "  clean  remove the build directory"

test:
	$(TOOL) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD)
	@out="$$(./$(BUILD)/V$(TOP))"; echo "$$out"; echo "$$out" | grep -qx "NO ERRORS"

clean:
	rm -rf $(BUILD)
